/* build.f */
+incdir+hdl
hdl/video_gen_pkg.sv
hdl/video_timing.sv
hdl/video_regs.sv
hdl/pointer_sprite.sv
hdl/pixel_out.sv
hdl/video_gen.sv
verification/video_gen_tb.sv

/* build.sh */
#!/bin/sh
# compile the video generator testbench with Verilator, run it, scan the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module video_gen_tb -o video_gen_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/video_gen_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0

/* verification/video_gen_tb.sv */
// testbench for the video generator: clock, reset, Wishbone access,
// pointer memory model, raster and color monitor, watchdog
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_macros.svh"

module video_gen_tb import video_gen_pkg::*; ();

localparam int CLK_PERIOD      = 100;
localparam int FRAME_CYCLES    = `H_TOTAL * `V_TOTAL;
localparam int WATCHDOG_CYCLES = 12 * FRAME_CYCLES + 2000;
localparam int ACK_WAIT        = 2;         // negedges from stb until ack is seen
localparam logic [3:0] PTR_COL = 4'hA;

logic clk;
logic reset_i;
logic wb_cyc_i;
logic wb_stb_i;
logic wb_we_i;
reg_num_t wb_adr_i;
word_t wb_dat_i;
word_t wb_dat_o;
logic wb_ack_o;
logic video_intr_o;
pointer_addr_t pointer_addr_o;
word_t pointer_data_i;
color_t color_index_o;
logic hsync_o;
logic vsync_o;
logic dv_de_o;
logic h_blank_o;
logic v_blank_o;

int checks;
int errors;
word_t mem [16];                            // pointer memory model
pointer_addr_t addr_q;
bit mon_on;
bit window_on;
color_t exp_fill;
color_t exp_border;
int exp_left;
int exp_right;
int cyc_cnt;
int hs_last;
int vs_last;
int intr_last;
int de_run;
int de_lines;
int hb_low;                                 // h_blank_o low clocks since last hsync
int hs_frame;
int intr_frame;
bit hs_q;
bit vs_q;
logic [3:0] ptr_seen [$];                   // lower nibbles of pointer pixels

video_gen video_gen_inst (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic fail_value(input string sig, input int expv, input int actv);
    errors++;
    $display("[FAIL] %0t ns %s expected %0h got %0h", $time, sig, expv, actv);
endtask

task automatic fail_event(input string what);
    errors++;
    $display("[FAIL] %0t ns %s", $time, what);
endtask

task automatic check_value(input string sig, input int expv, input int actv);
    checks++;
    assert (expv == actv) else fail_value(sig, expv, actv);
endtask

// fill inside [left, right), border elsewhere
function automatic color_t window_color(input int col);
    return (col >= exp_left && col < exp_right) ? exp_fill : exp_border;
endfunction

// bits that a register keeps, from the register table
function automatic word_t reg_mask(input int num);
    case (num)
        0:       return 16'hFFFF;
        2, 3, 4: return 16'h007F;
        5:       return 16'hF01F;
        default: return 16'h0000;
    endcase
endfunction

task automatic wb_access(input bit we, input reg_num_t adr, input word_t wdat,
                         output word_t rdat);
    int waits;
    @(posedge clk);
    #10;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    waits = 0;
    do begin
        @(negedge clk);
        waits++;
    end while (!wb_ack_o && waits < 20);
    if (!wb_ack_o) begin
        fail_event($sformatf("no ack from register %0d", adr));
    end else begin
        check_value("wb_ack_o delay", ACK_WAIT, waits);
    end
    rdat = wb_dat_o;
    @(posedge clk);
    #10;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk);
    check_value("wb_ack_o", 0, wb_ack_o);     // ack lasts one clock
endtask

// synchronous memory, data for the address seen one clock earlier
always begin
    @(posedge clk);
    #10;
    pointer_data_i = mem[addr_q];
    addr_q = pointer_addr_o;
end

always @(negedge clk) begin
    if (mon_on) begin
        cyc_cnt++;
        assert (!$isunknown(pointer_addr_o)) else fail_event("pointer_addr_o is unknown");
        // blank flags leave on the same edge as dv_de_o
        check_value("dv_de_o with h_blank_o and v_blank_o", !h_blank_o && !v_blank_o,
                    dv_de_o);
        if (!h_blank_o) begin
            hb_low++;
        end
        if (hsync_o && !hs_q) begin
            if (hs_last > 0) begin
                check_value("hsync_o period", `H_TOTAL, cyc_cnt - hs_last);
                check_value("h_blank_o low run", `H_VISIBLE, hb_low);
            end
            hb_low  = 0;
            hs_last = cyc_cnt;
            hs_frame++;
        end
        if (vsync_o && !vs_q) begin
            if (vs_last > 0) begin
                check_value("vsync_o period", FRAME_CYCLES, cyc_cnt - vs_last);
                check_value("hsync_o pulses per frame", `V_TOTAL, hs_frame);
                check_value("video_intr_o pulses per frame", 1, intr_frame);
            end
            check_value("dv_de_o lines", `V_VISIBLE, de_lines);
            vs_last    = cyc_cnt;
            de_lines   = 0;
            hs_frame   = 0;
            intr_frame = 0;
        end
        if (video_intr_o) begin
            if (intr_last > 0) begin
                check_value("video_intr_o period", FRAME_CYCLES, cyc_cnt - intr_last);
            end
            intr_last = cyc_cnt;
            intr_frame++;
        end
        if (dv_de_o) begin
            if (window_on) begin
                check_value("color_index_o", window_color(de_run), color_index_o);
            end
            if (color_index_o[7:4] == PTR_COL) begin
                ptr_seen.push_back(color_index_o[3:0]);
            end
            de_run++;
        end else begin
            check_value("color_index_o blanked", 0, color_index_o);
            if (de_run > 0) begin
                check_value("dv_de_o run", `H_VISIBLE, de_run);
                de_lines++;
                de_run = 0;
            end
        end
        hs_q = hsync_o;
        vs_q = vsync_o;
    end
end

initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("checks %0d errors %0d", checks, errors + 1);
    $display("tests failed");
    $finish;
end

initial begin
    word_t wr_data [8];
    word_t rd;
    int lo;
    int hi;
    logic [3:0] exp_nib [$];
    void'($urandom(15));
    for (int i = 0; i < 16; i++) begin
        mem[i] = 16'($urandom);
    end
    wr_data = '{16'hC3A5, 16'h0000, 16'hFFAB, 16'h1234,
                16'hFF64, 16'hFFE3, 16'hFFFF, 16'h5555};
    addr_q = '0;
    pointer_data_i = '0;
    reset_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_value("wb_ack_o", 0, wb_ack_o);
    check_value("video_intr_o", 0, video_intr_o);
    check_value("hsync_o", 0, hsync_o);
    check_value("vsync_o", 0, vsync_o);
    check_value("dv_de_o", 0, dv_de_o);
    check_value("color_index_o", 0, color_index_o);
    @(posedge clk);
    #10;
    reset_i = 1'b0;
    mon_on = 1'b1;

    // reset values, then writes with readback through the masks
    for (int r = 0; r < 8; r++) begin
        if (r != 1) begin
            wb_access(1'b0, reg_num_t'(r), '0, rd);
            check_value($sformatf("register %0d after reset", r), 0, rd);
        end
    end
    for (int r = 0; r < 8; r++) begin
        if (r != 1) begin
            wb_access(1'b1, reg_num_t'(r), wr_data[r], rd);
        end
    end
    for (int r = 0; r < 8; r++) begin
        if (r != 1) begin
            wb_access(1'b0, reg_num_t'(r), '0, rd);
            check_value($sformatf("register %0d", r), wr_data[r] & reg_mask(r), rd);
        end
    end

    // scanline spread across most of a frame
    lo = 99;
    hi = -1;
    repeat (8) begin
        wb_access(1'b0, `REG_SCANLINE, '0, rd);
        checks++;
        assert (rd < `V_TOTAL) else fail_event($sformatf("SCANLINE read %0d past last line", rd));
        lo = (int'(rd) < lo) ? int'(rd) : lo;
        hi = (int'(rd) > hi) ? int'(rd) : hi;
        repeat (250) @(posedge clk);
    end
    checks++;
    assert (hi > lo) else fail_event("SCANLINE did not change over a frame");

    // window and border with the pointer off-screen
    exp_fill = 8'h35;
    exp_border = 8'h5C;
    exp_left = 10;
    exp_right = 40;
    wb_access(1'b1, `REG_VID_CTRL, {exp_fill, exp_border}, rd);
    wb_access(1'b1, `REG_VID_LEFT, 16'(exp_left), rd);
    wb_access(1'b1, `REG_VID_RIGHT, 16'(exp_right), rd);
    wb_access(1'b1, `REG_POINTER_H, 16'd100, rd);
    @(posedge vsync_o);
    window_on = 1'b1;
    repeat (2) @(posedge vsync_o);
    window_on = 1'b0;

    // pointer at column 20, row 4
    wb_access(1'b1, `REG_POINTER_H, 16'd20, rd);
    wb_access(1'b1, `REG_POINTER_V, {PTR_COL, 12'd4}, rd);
    for (int a = 0; a < 16; a++) begin
        for (int n = 3; n >= 0; n--) begin
            if (mem[a][n*4 +: 4] != 4'h0) begin
                exp_nib.push_back(mem[a][n*4 +: 4]);    // msb nibble first
            end
        end
    end
    @(posedge vsync_o);
    ptr_seen.delete();
    @(posedge vsync_o);
    check_value("pointer pixel count", exp_nib.size(), ptr_seen.size());
    for (int n = 0; n < exp_nib.size() && n < ptr_seen.size(); n++) begin
        check_value($sformatf("pointer nibble %0d", n), exp_nib[n], ptr_seen[n]);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

`default_nettype wire

/* hdl/video_gen.sv */
// video generator top: register block, timing, pointer engine
// and the pixel output stage
`default_nettype none
`timescale 1ns/1ns

module video_gen import video_gen_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    // Wishbone classic slave
    input  wire logic       wb_cyc_i,
    input  wire logic       wb_stb_i,
    input  wire logic       wb_we_i,
    input  wire reg_num_t   wb_adr_i,
    input  wire word_t      wb_dat_i,
    output word_t           wb_dat_o,
    output logic            wb_ack_o,
    output logic            video_intr_o,
    // external pointer memory
    output pointer_addr_t   pointer_addr_o,
    input  wire word_t      pointer_data_i,
    // video out
    output color_t          color_index_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o,
    output logic            h_blank_o,
    output logic            v_blank_o
);

hres_t      h_count;
vres_t      v_count;
logic       h_visible;
logic       v_visible;
logic       hsync;
logic       vsync;
logic       end_of_visible;
color_t     border_color;
color_t     fill_color;
hres_t      vid_left;
hres_t      vid_right;
hres_t      pointer_h;
vres_t      pointer_v;
logic [3:0] pointer_col;
logic [3:0] pointer_color;      // sprite nibble, 0 transparent

video_regs video_regs_inst (
    .clk(clk),
    .reset_i(reset_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o),
    .v_count_i(v_count),
    .end_of_visible_i(end_of_visible),
    .border_color_o(border_color),
    .fill_color_o(fill_color),
    .vid_left_o(vid_left),
    .vid_right_o(vid_right),
    .pointer_h_o(pointer_h),
    .pointer_v_o(pointer_v),
    .pointer_col_o(pointer_col),
    .video_intr_o(video_intr_o)
);

video_timing video_timing_inst (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_o(h_count),
    .v_count_o(v_count),
    .h_visible_o(h_visible),
    .v_visible_o(v_visible),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .end_of_visible_o(end_of_visible)
);

pointer_sprite pointer_sprite_inst (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_i(h_count),
    .v_count_i(v_count),
    .pointer_h_i(pointer_h),
    .pointer_v_i(pointer_v),
    .pointer_addr_o(pointer_addr_o),
    .pointer_data_i(pointer_data_i),
    .pointer_color_o(pointer_color)
);

pixel_out pixel_out_inst (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_i(h_count),
    .h_visible_i(h_visible),
    .v_visible_i(v_visible),
    .hsync_i(hsync),
    .vsync_i(vsync),
    .border_color_i(border_color),
    .fill_color_i(fill_color),
    .vid_left_i(vid_left),
    .vid_right_i(vid_right),
    .pointer_col_i(pointer_col),
    .pointer_color_i(pointer_color),
    .color_index_o(color_index_o),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .dv_de_o(dv_de_o),
    .h_blank_o(h_blank_o),
    .v_blank_o(v_blank_o)
);

endmodule

`default_nettype wire

/* hdl/pixel_out.sv */
// color choice for border, window and pointer, with the raster delay
// and the aligned output registers
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_macros.svh"

module pixel_out import video_gen_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire hres_t      h_count_i,
    input  wire logic       h_visible_i,
    input  wire logic       v_visible_i,
    input  wire logic       hsync_i,
    input  wire logic       vsync_i,
    input  wire color_t     border_color_i,
    input  wire color_t     fill_color_i,
    input  wire hres_t      vid_left_i,
    input  wire hres_t      vid_right_i,
    input  wire logic [3:0] pointer_col_i,
    input  wire logic [3:0] pointer_color_i,
    output color_t          color_index_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o,
    output logic            h_blank_o,
    output logic            v_blank_o
);

localparam int DLY      = `POINTER_LATENCY;
localparam int RASTER_W = $bits(hres_t) + 4;

logic [RASTER_W-1:0] raster_dly [DLY];      // count, visible flags, syncs
hres_t               h_count_d;
logic                h_vis_d;
logic                v_vis_d;
logic                hsync_d;
logic                vsync_d;
logic                visible;
logic                in_window;
color_t              color_next;

assign {h_count_d, h_vis_d, v_vis_d, hsync_d, vsync_d} = raster_dly[DLY-1];
assign visible   = h_vis_d & v_vis_d;
assign in_window = (h_count_d >= vid_left_i) && (h_count_d < vid_right_i);

always_comb begin
    color_next = in_window ? fill_color_i : border_color_i;
    if (pointer_color_i != 4'h0) begin
        color_next = {pointer_col_i, pointer_color_i};  // pointer on top
    end
    if (!visible) begin
        color_next = '0;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        for (int i = 0; i < DLY; i++) begin
            raster_dly[i] <= '0;
        end
        color_index_o <= '0;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        dv_de_o       <= 1'b0;
        h_blank_o     <= 1'b1;
        v_blank_o     <= 1'b1;
    end else begin
        raster_dly[0] <= {h_count_i, h_visible_i, v_visible_i, hsync_i, vsync_i};
        for (int i = 1; i < DLY; i++) begin
            raster_dly[i] <= raster_dly[i-1];
        end
        // all video outputs leave on the same edge
        color_index_o <= color_next;
        hsync_o       <= hsync_d;
        vsync_o       <= vsync_d;
        dv_de_o       <= visible;
        h_blank_o     <= ~h_vis_d;
        v_blank_o     <= ~v_vis_d;
    end
end

endmodule

`default_nettype wire

/* hdl/pointer_sprite.sv */
// 8x8 4-bpp pointer engine: row and column counters, memory address
// and the nibble shifter
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_macros.svh"

module pointer_sprite import video_gen_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire hres_t      h_count_i,
    input  wire vres_t      v_count_i,
    input  wire hres_t      pointer_h_i,
    input  wire vres_t      pointer_v_i,
    output pointer_addr_t   pointer_addr_o,
    input  wire word_t      pointer_data_i,     // one clock after address
    output logic [3:0]      pointer_color_o     // 0 is transparent
);

// column count runs 3 past the size to cover the fetch delay
localparam int H_CNT_END = `POINTER_SIZE + 3;

logic [3:0] h_cnt;
logic [3:0] v_cnt;
word_t      pointer_word;       // shifts left a nibble per clock
logic       h_draw;
logic       v_draw;

assign h_draw = (h_cnt < 4'(H_CNT_END));
assign v_draw = (v_cnt < 4'(`POINTER_SIZE));

// two words per row, second half once bit 2 of the column is set
assign pointer_addr_o  = {v_cnt[2:0], h_cnt[2]};
assign pointer_color_o = pointer_word[15:12];

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_cnt        <= 4'(H_CNT_END);          // parked, nothing drawn
        v_cnt        <= 4'(`POINTER_SIZE);
        pointer_word <= '0;
    end else begin
        pointer_word <= {pointer_word[11:0], 4'h0};
        if (h_draw) begin
            h_cnt <= h_cnt + 1'b1;
        end

        if (h_count_i == pointer_h_i) begin
            h_cnt <= '0;                        // restart at pointer column
            if (v_count_i == pointer_v_i) begin
                v_cnt <= '0;
            end else if (v_draw) begin
                v_cnt <= v_cnt + 1'b1;
            end
        end

        if (h_cnt[1:0] == 2'b11) begin
            pointer_word <= pointer_data_i;     // word addressed last clock
        end

        if (!h_draw || !v_draw) begin
            pointer_word <= '0;                 // outside the 8x8 area
        end
    end
end

endmodule

`default_nettype wire

/* hdl/video_regs.sv */
// Wishbone classic slave with the video configuration registers
// and the end-of-visible interrupt
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_macros.svh"

module video_regs import video_gen_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    // Wishbone classic slave
    input  wire logic       wb_cyc_i,
    input  wire logic       wb_stb_i,
    input  wire logic       wb_we_i,
    input  wire reg_num_t   wb_adr_i,
    input  wire word_t      wb_dat_i,
    output word_t           wb_dat_o,
    output logic            wb_ack_o,
    // raster state
    input  wire vres_t      v_count_i,
    input  wire logic       end_of_visible_i,
    // settings
    output color_t          border_color_o,
    output color_t          fill_color_o,
    output hres_t           vid_left_o,
    output hres_t           vid_right_o,
    output hres_t           pointer_h_o,
    output vres_t           pointer_v_o,
    output logic [3:0]      pointer_col_o,      // upper nibble of pointer pixels
    output logic            video_intr_o
);

logic   access;     // new request, ack not yet given
word_t  rd_word;

assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

// read word, unused bits stay 0
always_comb begin
    rd_word = '0;
    case (wb_adr_i)
        `REG_VID_CTRL:  rd_word = {fill_color_o, border_color_o};
        `REG_SCANLINE:  rd_word = word_t'(v_count_i);
        `REG_VID_LEFT:  rd_word = word_t'(vid_left_o);
        `REG_VID_RIGHT: rd_word = word_t'(vid_right_o);
        `REG_POINTER_H: rd_word = word_t'(pointer_h_o);
        `REG_POINTER_V: rd_word = {pointer_col_o, 7'b0, pointer_v_o};
        default:        ;                       // 6 and 7 read 0
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        wb_ack_o       <= 1'b0;
        wb_dat_o       <= '0;
        video_intr_o   <= 1'b0;
        border_color_o <= '0;
        fill_color_o   <= '0;
        vid_left_o     <= '0;
        vid_right_o    <= '0;
        pointer_h_o    <= '0;
        pointer_v_o    <= '0;
        pointer_col_o  <= '0;
    end else begin
        wb_ack_o     <= access;                 // single clock ack
        video_intr_o <= end_of_visible_i;

        if (access) begin
            wb_dat_o <= rd_word;                // valid while ack high
        end

        if (access && wb_we_i) begin
            case (wb_adr_i)
                `REG_VID_CTRL: begin
                    fill_color_o   <= wb_dat_i[15:8];
                    border_color_o <= wb_dat_i[7:0];
                end
                `REG_VID_LEFT:  vid_left_o  <= hres_t'(wb_dat_i);
                `REG_VID_RIGHT: vid_right_o <= hres_t'(wb_dat_i);
                `REG_POINTER_H: pointer_h_o <= hres_t'(wb_dat_i);
                `REG_POINTER_V: begin
                    pointer_col_o <= wb_dat_i[15:12];
                    pointer_v_o   <= vres_t'(wb_dat_i);
                end
                default: ;                      // scanline and spare numbers are read only
            endcase
        end
    end
end

endmodule

`default_nettype wire

/* hdl/video_timing.sv */
// raster counters with sync, visible flags and the end-of-visible event
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_macros.svh"

module video_timing import video_gen_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    output hres_t       h_count_o,          // 0 is first visible pixel
    output vres_t       v_count_o,          // 0 is first visible line
    output logic        h_visible_o,
    output logic        v_visible_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        end_of_visible_o    // one clock per frame
);

localparam hres_t H_LAST       = hres_t'(`H_TOTAL - 1);
localparam hres_t H_SYNC_START = hres_t'(`H_VISIBLE + `H_FRONT);
localparam hres_t H_SYNC_END   = hres_t'(`H_VISIBLE + `H_FRONT + `H_SYNC);
localparam vres_t V_LAST       = vres_t'(`V_TOTAL - 1);
localparam vres_t V_SYNC_START = vres_t'(`V_VISIBLE + `V_FRONT);
localparam vres_t V_SYNC_END   = vres_t'(`V_VISIBLE + `V_FRONT + `V_SYNC);

logic end_of_line;
logic end_of_frame;

assign end_of_line  = (h_count_o == H_LAST);
assign end_of_frame = end_of_line && (v_count_o == V_LAST);

// compare-based flags straight off the counters
assign h_visible_o = (h_count_o < hres_t'(`H_VISIBLE));
assign v_visible_o = (v_count_o < vres_t'(`V_VISIBLE));
assign hsync_o     = (h_count_o >= H_SYNC_START) && (h_count_o < H_SYNC_END);
assign vsync_o     = (v_count_o >= V_SYNC_START) && (v_count_o < V_SYNC_END);

// first clock after the last visible pixel of the last visible line
assign end_of_visible_o = (h_count_o == hres_t'(`H_VISIBLE)) &&
                          (v_count_o == vres_t'(`V_VISIBLE - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o <= '0;
        v_count_o <= '0;
    end else begin
        if (end_of_line) begin
            h_count_o <= '0;
            if (end_of_frame) begin
                v_count_o <= '0;                // wrap to top of frame
            end else begin
                v_count_o <= v_count_o + 1'b1;
            end
        end else begin
            h_count_o <= h_count_o + 1'b1;
        end
    end
end

endmodule

`default_nettype wire

/* hdl/video_gen_pkg.sv */
// shared types of the video generator
`default_nettype none

package video_gen_pkg;

    // register data word
    typedef logic [15:0] word_t;

    // palette index out of the generator
    typedef logic [7:0] color_t;

    // raster counts, wide enough for the totals
    typedef logic [6:0] hres_t;             // 0 to 87
    typedef logic [4:0] vres_t;             // 0 to 23

    // Wishbone register number
    typedef logic [2:0] reg_num_t;

    // pointer memory word address
    // 3 row bits and one half-row bit, 4 nibbles per word
    typedef logic [3:0] pointer_addr_t;

endpackage

`default_nettype wire

/* hdl/video_gen_macros.svh */
// raster segment sizes, pointer size and latency, register numbers
`ifndef VIDEO_GEN_MACROS_SVH
`define VIDEO_GEN_MACROS_SVH

// horizontal raster in pixel clocks
`define H_VISIBLE       64
`define H_FRONT         4
`define H_SYNC          8
`define H_BACK          12
`define H_TOTAL         (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical raster in lines
`define V_VISIBLE       16
`define V_FRONT         2
`define V_SYNC          2
`define V_BACK          4
`define V_TOTAL         (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

`define POINTER_SIZE    8       // pointer is square, 4-bpp
`define POINTER_LATENCY 5       // raster clocks from column match to first nibble

// register numbers on the Wishbone port
`define REG_VID_CTRL    3'd0
`define REG_SCANLINE    3'd1
`define REG_VID_LEFT    3'd2
`define REG_VID_RIGHT   3'd3
`define REG_POINTER_H   3'd4
`define REG_POINTER_V   3'd5

`endif
